// File: design/aesPkg.sv
`default_nettype none

package aesPkg;

        // sixteen bytes in column order, byte 0 in the top bits.
        typedef logic [0:15][7:0] blockT;

        typedef logic [31:0] wordT;
        typedef logic [255:0] cipherKeyT;

        // round index, 0 to 14.
        typedef logic [3:0] roundIdxT;

        localparam int NumRounds = 14;  // aes-256.

endpackage

`default_nettype wire

// File: design/aesMathPkg.sv
`default_nettype none

package aesMathPkg;
        import aesPkg::*;

        function automatic logic [7:0] xtime(input logic [7:0] b);
                return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
        endfunction

        function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
                logic [7:0] acc;
                logic [7:0] p;
                acc = 8'h00;
                p = a;
                for (int i = 0; i < 8; i++)
                begin
                        if (b[i])
                                acc = acc ^ p;
                        p = xtime(p);
                end
                return acc;
        endfunction

        // inverse as a^254, the product of a^2 up to a^128.
        function automatic logic [7:0] gfInv(input logic [7:0] a);
                logic [7:0] sq;
                logic [7:0] acc;
                sq = a;
                acc = 8'h01;
                for (int k = 1; k < 8; k++)
                begin
                        sq = gfMul(sq, sq);
                        acc = gfMul(acc, sq);
                end
                return acc;
        endfunction

        function automatic logic [7:0] rotByte(input logic [7:0] b, input int n);
                logic [15:0] d;
                d = {b, b} << n;
                return d[15:8];
        endfunction

        function automatic logic [7:0] subByte(input logic [7:0] b);
                logic [7:0] x;
                x = gfInv(b);
                return x ^ rotByte(x, 1) ^ rotByte(x, 2) ^ rotByte(x, 3) ^ rotByte(x, 4) ^ 8'h63;
        endfunction

        function automatic logic [7:0] invSubByte(input logic [7:0] b);
                return gfInv(rotByte(b, 1) ^ rotByte(b, 3) ^ rotByte(b, 6) ^ 8'h05);
        endfunction

        function automatic wordT subWord(input wordT w);
                return {subByte(w[31:24]), subByte(w[23:16]), subByte(w[15:8]), subByte(w[7:0])};
        endfunction

        function automatic wordT rotWord(input wordT w);
                return {w[23:0], w[31:24]};
        endfunction

        // row r moves right by r columns.
        function automatic blockT invShiftRows(input blockT s);
                blockT res;
                for (int c = 0; c < 4; c++)
                        for (int r = 0; r < 4; r++)
                                res[4 * c + r] = s[4 * ((c - r + 4) % 4) + r];
                return res;
        endfunction

        function automatic blockT invSubBytes(input blockT s);
                blockT res;
                for (int i = 0; i < 16; i++)
                        res[i] = invSubByte(s[i]);
                return res;
        endfunction

        function automatic blockT invMixColumns(input blockT s);
                blockT res;
                logic [7:0] a0, a1, a2, a3;
                for (int c = 0; c < 4; c++)
                begin
                        a0 = s[4 * c];
                        a1 = s[4 * c + 1];
                        a2 = s[4 * c + 2];
                        a3 = s[4 * c + 3];
                        res[4 * c] = gfMul(a0, 8'h0e) ^ gfMul(a1, 8'h0b) ^ gfMul(a2, 8'h0d) ^ gfMul(a3, 8'h09);
                        res[4 * c + 1] = gfMul(a0, 8'h09) ^ gfMul(a1, 8'h0e) ^ gfMul(a2, 8'h0b) ^ gfMul(a3, 8'h0d);
                        res[4 * c + 2] = gfMul(a0, 8'h0d) ^ gfMul(a1, 8'h09) ^ gfMul(a2, 8'h0e) ^ gfMul(a3, 8'h0b);
                        res[4 * c + 3] = gfMul(a0, 8'h0b) ^ gfMul(a1, 8'h0d) ^ gfMul(a2, 8'h09) ^ gfMul(a3, 8'h0e);
                end
                return res;
        endfunction

        function automatic blockT addRoundKey(input blockT s, input blockT k);
                return s ^ k;
        endfunction

endpackage

`default_nettype wire

// File: design/roundCounter.sv
`default_nettype none

module roundCounter
        import aesPkg::*;
#(
        parameter int LastRound = 14
)
(
        input wire clk,
        input wire rst,
        input wire expandStart,
        input wire decryptStart,
        input wire advance,
        output roundIdxT roundIdx,
        output logic lastStep
);

        logic countUp;  // set while expanding keys.

        always_ff @(posedge clk)
        begin
                if (rst)
                begin
                        roundIdx <= '0;
                        countUp <= 1'b1;
                end
                else if (expandStart)
                begin
                        roundIdx <= roundIdxT'(2);  // keys 0 and 1 come from the cipher key.
                        countUp <= 1'b1;
                end
                else if (decryptStart)
                begin
                        roundIdx <= roundIdxT'(LastRound - 1);
                        countUp <= 1'b0;
                end
                else if (advance && !lastStep)  // holds at the end value.
                        roundIdx <= countUp ? roundIdx + 1'b1 : roundIdx - 1'b1;
        end

        assign lastStep = countUp ? (roundIdx == roundIdxT'(LastRound)) : (roundIdx == '0);

endmodule

`default_nettype wire

// File: design/decryptCtrl.sv
`default_nettype none

module decryptCtrl
(
        input wire clk,
        input wire rst,
        input wire keyLoad,
        input wire start,
        input wire lastStep,
        output logic expandStart,
        output logic decryptStart,
        output logic advance,
        output logic keyReady,
        output logic busy,
        output logic done
);

        typedef enum logic [1:0] {
                Idle,
                Expand,
                Decrypt
        } stateT;

        stateT state;

        // a key load wins over a start in the same cycle.
        assign expandStart = (state == Idle) && keyLoad;
        assign decryptStart = (state == Idle) && !keyLoad && start && keyReady;
        assign advance = (state != Idle);
        assign busy = (state == Decrypt);

        always_ff @(posedge clk)
        begin
                if (rst)
                begin
                        state <= Idle;
                        keyReady <= 1'b0;
                        done <= 1'b0;
                end
                else
                begin
                        done <= 1'b0;
                        case (state)
                                Idle:
                                begin
                                        if (expandStart)
                                        begin
                                                state <= Expand;
                                                keyReady <= 1'b0;  // old keys are being replaced.
                                        end
                                        else if (decryptStart)
                                                state <= Decrypt;
                                end
                                Expand:
                                begin
                                        if (lastStep)
                                        begin
                                                state <= Idle;
                                                keyReady <= 1'b1;
                                        end
                                end
                                Decrypt:
                                begin
                                        if (lastStep)
                                        begin
                                                state <= Idle;
                                                done <= 1'b1;
                                        end
                                end
                                default: state <= Idle;
                        endcase
                end
        end

endmodule

`default_nettype wire

// File: design/keyExpander.sv
`default_nettype none

module keyExpander
        import aesPkg::*;
        import aesMathPkg::*;
(
        input wire clk,
        input wire keyLoad,
        input wire cipherKeyT cipherKey,
        input wire advance,
        input wire roundIdxT roundIdx,
        output logic keyInitWr,
        output cipherKeyT initKeys,
        output logic newKeyWr,
        output blockT newKey
);

        cipherKeyT window;  // round keys i-2 and i-1.
        logic [7:0] rcon;
        logic expanding;
        wordT temp;
        wordT w0, w1, w2, w3;

        assign keyInitWr = keyLoad;
        assign initKeys = cipherKey;

        // advance also runs during decryption, only expansion steps write.
        assign newKeyWr = advance && expanding;

        always_comb
        begin
                if (roundIdx[0] == 1'b0)
                        temp = subWord(rotWord(window[31:0])) ^ {rcon, 24'h000000};
                else
                        temp = subWord(window[31:0]);
                w0 = window[255:224] ^ temp;
                w1 = window[223:192] ^ w0;
                w2 = window[191:160] ^ w1;
                w3 = window[159:128] ^ w2;
        end

        assign newKey = {w0, w1, w2, w3};

        always_ff @(posedge clk)
        begin
                if (keyLoad)
                begin
                        window <= cipherKey;
                        rcon <= 8'h01;
                        expanding <= 1'b1;
                end
                else if (newKeyWr)
                begin
                        window <= {window[127:0], newKey};
                        if (roundIdx[0] == 1'b0)
                                rcon <= xtime(rcon);  // next even key.
                        if (roundIdx == roundIdxT'(NumRounds))
                                expanding <= 1'b0;
                end
        end

endmodule

`default_nettype wire

// File: design/roundKeyStore.sv
`default_nettype none

module roundKeyStore
        import aesPkg::*;
#(
        parameter int LastRound = 14
)
(
        input wire clk,
        input wire keyInitWr,
        input wire cipherKeyT initKeys,
        input wire newKeyWr,
        input wire blockT newKey,
        input wire roundIdxT roundIdx,
        output blockT roundKey,
        output blockT finalKey
);

        blockT keys [0:LastRound];

        always_ff @(posedge clk)
        begin
                if (keyInitWr)
                begin
                        keys[0] <= initKeys[255:128];
                        keys[1] <= initKeys[127:0];
                end
                else if (newKeyWr)
                        keys[roundIdx] <= newKey;
        end

        assign roundKey = keys[roundIdx];
        assign finalKey = keys[LastRound];  // used for the initial key addition.

endmodule

`default_nettype wire

// File: design/invRoundPath.sv
`default_nettype none

module invRoundPath
        import aesPkg::*;
        import aesMathPkg::*;
(
        input wire clk,
        input wire rst,
        input wire decryptStart,
        input wire advance,
        input wire lastStep,
        input wire blockT cipherText,
        input wire blockT roundKey,
        input wire blockT finalKey,
        output blockT plainText
);

        blockT state;
        blockT afterKey;
        blockT nextState;
        logic running;  // a block is in flight.

        assign afterKey = addRoundKey(invSubBytes(invShiftRows(state)), roundKey);

        // the final round has no InvMixColumns.
        assign nextState = lastStep ? afterKey : invMixColumns(afterKey);

        always_ff @(posedge clk)
        begin
                if (decryptStart)
                        state <= addRoundKey(cipherText, finalKey);
                else if (advance)
                        state <= nextState;
        end

        always_ff @(posedge clk)
        begin
                if (rst)
                begin
                        running <= 1'b0;
                        plainText <= '0;
                end
                else if (decryptStart)
                        running <= 1'b1;
                else if (running && advance && lastStep)
                begin
                        running <= 1'b0;
                        plainText <= nextState;  // held until the next block ends.
                end
        end

endmodule

`default_nettype wire

// File: design/aesInvTop.sv
`default_nettype none

module aesInvTop
(
        input wire clk,
        input wire rst,
        input wire keyLoad,
        input wire aesPkg::cipherKeyT cipherKey,
        input wire start,
        input wire aesPkg::blockT cipherText,
        output logic keyReady,
        output logic busy,
        output logic done,
        output aesPkg::blockT plainText
);

        localparam int LastRound = aesPkg::NumRounds;

        logic expandStart;
        logic decryptStart;
        logic advance;
        aesPkg::roundIdxT roundIdx;
        logic lastStep;
        logic keyInitWr;
        aesPkg::cipherKeyT initKeys;
        logic newKeyWr;
        aesPkg::blockT newKey;
        aesPkg::blockT roundKey;
        aesPkg::blockT finalKey;

        decryptCtrl u_ctrl (
                .clk(clk),
                .rst(rst),
                .keyLoad(keyLoad),
                .start(start),
                .lastStep(lastStep),
                .expandStart(expandStart),
                .decryptStart(decryptStart),
                .advance(advance),
                .keyReady(keyReady),
                .busy(busy),
                .done(done)
        );

        roundCounter #(.LastRound(LastRound)) u_counter (
                .clk(clk),
                .rst(rst),
                .expandStart(expandStart),
                .decryptStart(decryptStart),
                .advance(advance),
                .roundIdx(roundIdx),
                .lastStep(lastStep)
        );

        keyExpander u_expander (
                .clk(clk),
                .keyLoad(expandStart),  // only the accepted load.
                .cipherKey(cipherKey),
                .advance(advance),
                .roundIdx(roundIdx),
                .keyInitWr(keyInitWr),
                .initKeys(initKeys),
                .newKeyWr(newKeyWr),
                .newKey(newKey)
        );

        roundKeyStore #(.LastRound(LastRound)) u_keyStore (
                .clk(clk),
                .keyInitWr(keyInitWr),
                .initKeys(initKeys),
                .newKeyWr(newKeyWr),
                .newKey(newKey),
                .roundIdx(roundIdx),
                .roundKey(roundKey),
                .finalKey(finalKey)
        );

        invRoundPath u_roundPath (
                .clk(clk),
                .rst(rst),
                .decryptStart(decryptStart),
                .advance(advance),
                .lastStep(lastStep),
                .cipherText(cipherText),
                .roundKey(roundKey),
                .finalKey(finalKey),
                .plainText(plainText)
        );

endmodule

`default_nettype wire

// File: bench/aesInvTb.sv
`default_nettype none

module aesInvTb
        import aesPkg::*;
();

        timeunit 1ns;
        timeprecision 1ps;

        localparam int ClkPeriod = 20;
        localparam int TestCycles = 200;
        // edges counted from the one that drives the strobe. the DUT samples it one edge later.
        localparam int KeyEdges = 1 + 13;
        localparam int DoneEdges = 1 + 14;
        localparam int BusyCycles = 14;  // from the start edge up to the done edge.

        localparam cipherKeyT FipsKey =
                256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f;
        localparam blockT FipsCipher = 128'h8ea2b7ca516745bfeafc49904b496089;
        localparam blockT FipsPlain = 128'h00112233445566778899aabbccddeeff;
        localparam blockT ZeroCipher = 128'hdc95c078a2408989ad48a21492842087;

        logic clk;
        logic rst;
        logic keyLoad;
        cipherKeyT cipherKey;
        logic start;
        blockT cipherText;
        logic keyReady;
        logic busy;
        logic done;
        blockT plainText;

        int checks;
        int errors;
        logic [31:0] lcgState;

        aesInvTop u_dut (
                .clk(clk),
                .rst(rst),
                .keyLoad(keyLoad),
                .cipherKey(cipherKey),
                .start(start),
                .cipherText(cipherText),
                .keyReady(keyReady),
                .busy(busy),
                .done(done),
                .plainText(plainText)
        );

        initial
        begin
                clk = 1'b0;
                forever #(ClkPeriod / 2) clk = ~clk;
        end

        function automatic logic [31:0] nextRandom();
                lcgState = lcgState * 32'd1664525 + 32'd1013904223;
                return lcgState;
        endfunction

        function automatic blockT randomBlock();
                return {nextRandom(), nextRandom(), nextRandom(), nextRandom()};
        endfunction

        task automatic verifyBlock(input string name, input blockT expected, input blockT actual);
                checks++;
                assert (actual == expected)
                else
                begin
                        errors++;
                        $display("ERROR %s: expected %h, actual %h", name, expected, actual);
                end
        endtask

        task automatic checkValue(input string name, input int expected, input int actual);
                checks++;
                assert (actual == expected)
                else
                begin
                        errors++;
                        $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
                end
        endtask

        task automatic loadKey(input string name, input cipherKeyT key);
                int edges;
                edges = 0;
                @(posedge clk);
                keyLoad <= 1'b1;
                cipherKey <= key;
                do
                begin
                        @(posedge clk);
                        edges++;
                        keyLoad <= 1'b0;
                        @(negedge clk);
                end
                while (!keyReady && edges < 40);
                checkValue({name, " key ready edges"}, KeyEdges, edges);
        endtask

        // disturb 1 adds ignored start pulses and 2 adds a keyLoad pulse while busy.
        task automatic decryptBlock(input string name, input blockT ct, input blockT expected,
                        input int disturb);
                int edges;
                int busyCycles;
                edges = 0;
                busyCycles = 0;
                @(posedge clk);
                start <= 1'b1;
                cipherText <= ct;
                do
                begin
                        @(posedge clk);
                        edges++;
                        start <= 1'b0;
                        keyLoad <= 1'b0;
                        if (disturb == 1 && edges < 10 && edges % 2 == 1)
                        begin
                                start <= 1'b1;
                                cipherText <= randomBlock();
                        end
                        if (disturb == 2 && edges == 4)
                        begin
                                keyLoad <= 1'b1;
                                cipherKey <= '0;
                        end
                        @(negedge clk);
                        busyCycles += busy;
                end
                while (!done && edges < 40);
                checks++;
                assert (done)
                else
                begin
                        errors++;
                        $display("%s: the decryption never signalled done", name);
                end
                checkValue({name, " done edges"}, DoneEdges, edges);
                checkValue({name, " busy cycles"}, BusyCycles, busyCycles);
                checkValue({name, " busy at done"}, 0, busy);
                verifyBlock({name, " plainText"}, expected, plainText);
        endtask

        task automatic idleStartIgnored();
                int doneSeen;
                doneSeen = 0;
                checkValue("reset keyReady", 0, keyReady);
                checkValue("reset busy", 0, busy);
                checkValue("reset done", 0, done);
                verifyBlock("reset plainText", '0, plainText);
                @(posedge clk);
                start <= 1'b1;
                cipherText <= FipsCipher;
                @(posedge clk);
                start <= 1'b0;
                repeat (20)
                begin
                        @(negedge clk);
                        doneSeen += done;
                end
                checkValue("start without key", 0, doneSeen);
        endtask

        task automatic fipsKnownAnswer();
                loadKey("fips", FipsKey);
                decryptBlock("fips", FipsCipher, FipsPlain, 0);
                @(negedge clk);
                checkValue("fips done width", 0, done);
        endtask

        task automatic zeroKeyKnownAnswer();
                loadKey("zero key", '0);
                decryptBlock("zero key", ZeroCipher, '0, 0);
        endtask

        task automatic keyReuse();
                loadKey("reuse", FipsKey);
                decryptBlock("reuse 1", FipsCipher, FipsPlain, 1);
                decryptBlock("reuse 2", FipsCipher, FipsPlain, 1);
                decryptBlock("reuse 3", FipsCipher, FipsPlain, 1);
        endtask

        task automatic loadWhileBusy();
                decryptBlock("load while busy", FipsCipher, FipsPlain, 2);
                checkValue("load while busy keyReady", 1, keyReady);
                decryptBlock("after ignored load", FipsCipher, FipsPlain, 0);  // keys unchanged.
        endtask

        initial
        begin
                #(3 * TestCycles * ClkPeriod);
                $display("watchdog: the run did not finish in time");
                $display("ERRORS FOUND");
                $finish;
        end

        initial
        begin
                checks = 0;
                errors = 0;
                lcgState = 32'h2bce_b182;
                rst = 1'b1;
                keyLoad = 1'b0;
                cipherKey = '0;
                start = 1'b0;
                cipherText = '0;
                repeat (10) @(posedge clk);
                rst <= 1'b0;
                @(negedge clk);
                idleStartIgnored();
                fipsKnownAnswer();
                zeroKeyKnownAnswer();
                keyReuse();
                loadWhileBusy();
                $display("checks: %0d, errors: %0d", checks, errors);
                if (errors == 0)
                        $display("NO ERRORS");
                else
                        $display("ERRORS FOUND");
                $finish;
        end

endmodule

`default_nettype wire

// File: src.f
design/aesPkg.sv
design/aesMathPkg.sv
design/roundCounter.sv
design/decryptCtrl.sv
design/keyExpander.sv
design/roundKeyStore.sv
design/invRoundPath.sv
design/aesInvTop.sv
bench/aesInvTb.sv
